//--- sources.f
src/btb_pkg.sv
src/btb_tag_hash.sv
src/btb_ram.sv
src/btb_fetch_front.sv
src/btb_slot_bank.sv
src/btb_resp_collect.sv
src/btb.sv
test/tb_clock.sv
test/btb_properties.sv
test/btb_tb.sv

//--- src/btb.sv
// btb top: fetch front end feeding four slot banks, drained by the response collector
`timescale 1ns/100ps

module btb (
    input  logic                                 CLK,
    input  logic                                 nRST,

    // lookup request
    input  logic                                 valid_req,
    input  logic [btb_pkg::PC_WIDTH-1:0]         pc_req,
    input  logic [btb_pkg::ASID_WIDTH-1:0]       asid,

    // update, two cycles
    input  logic                                 update0_valid,
    input  logic [btb_pkg::PC_WIDTH-1:0]         update0_pc,
    input  logic [btb_pkg::PRED_INFO_WIDTH-1:0]  update1_pred_info,
    input  logic                                 update1_pred_lru,
    input  logic [btb_pkg::PC_WIDTH-1:0]         update1_target_pc,

    // lookup response
    output logic                                 resp_valid,
    output logic [btb_pkg::NSLOTS-1:0]           hit_by_slot,
    output logic [btb_pkg::NSLOTS-1:0][btb_pkg::PRED_INFO_WIDTH-1:0] pred_info_by_slot,
    output logic [btb_pkg::NSLOTS-1:0][btb_pkg::TARGET_WIDTH-1:0]    target_by_slot,
    output logic [btb_pkg::NSLOTS-1:0]           lru_by_slot,
    output logic                                 first_hit_valid,
    output logic [btb_pkg::LOG_NSLOTS-1:0]       first_hit_slot,
    output logic [btb_pkg::TARGET_WIDTH-1:0]     first_hit_target
);

    import btb_pkg::*;

    // front end to banks
    logic                   bank_ren;
    logic [INDEX_WIDTH-1:0] bank_rindex;
    logic [TAG_WIDTH-1:0]   resp_tag;
    logic [NSLOTS-1:0]      wr_slot_en;
    logic [INDEX_WIDTH-1:0] wr_index;
    logic                   wr_way;
    btb_entry_t             wr_entry;

    // front end to collector
    logic [LOG_NSLOTS-1:0]  resp_offset;
    lru_vec_t               resp_lru;

    // banks to collector
    logic [NSLOTS-1:0]                      bank_hit;
    logic [NSLOTS-1:0]                      bank_hit_way;
    logic [NSLOTS-1:0][PRED_INFO_WIDTH-1:0] bank_pred_info;
    logic [NSLOTS-1:0][TARGET_WIDTH-1:0]    bank_target;

    // ---------------------------------------------------------
    // front end
    btb_fetch_front u_front (
        .CLK(CLK), .nRST(nRST),
        .valid_req(valid_req), .pc_req(pc_req), .asid(asid),
        .update0_valid(update0_valid), .update0_pc(update0_pc),
        .update1_pred_info(update1_pred_info), .update1_pred_lru(update1_pred_lru),
        .update1_target_pc(update1_target_pc),
        .bank_ren(bank_ren), .bank_rindex(bank_rindex), .resp_tag(resp_tag),
        .resp_valid(resp_valid), .resp_offset(resp_offset), .resp_lru(resp_lru),
        .wr_slot_en(wr_slot_en), .wr_index(wr_index), .wr_way(wr_way),
        .wr_entry(wr_entry)
    );

    // ---------------------------------------------------------
    // slot banks
    // shared read and write buses, private write enable
    generate
        for (genvar s = 0; s < NSLOTS; s++) begin : g_slot
            btb_slot_bank u_bank (
                .CLK(CLK), .nRST(nRST),
                .ren(bank_ren), .rindex(bank_rindex), .resp_tag(resp_tag),
                .wen(wr_slot_en[s]), .windex(wr_index), .wway(wr_way),
                .wentry(wr_entry),
                .hit(bank_hit[s]), .hit_way(bank_hit_way[s]),
                .pred_info(bank_pred_info[s]), .target(bank_target[s])
            );
        end
    endgenerate

    // ---------------------------------------------------------
    // collector
    btb_resp_collect u_collect (
        .resp_valid(resp_valid), .resp_offset(resp_offset), .resp_lru(resp_lru),
        .hit(bank_hit), .hit_way(bank_hit_way),
        .pred_info(bank_pred_info), .target(bank_target),
        .hit_by_slot(hit_by_slot), .pred_info_by_slot(pred_info_by_slot),
        .target_by_slot(target_by_slot), .lru_by_slot(lru_by_slot),
        .first_hit_valid(first_hit_valid), .first_hit_slot(first_hit_slot),
        .first_hit_target(first_hit_target)
    );

endmodule

//--- src/btb_fetch_front.sv
// btb fetch front: decodes lookups, runs the two-cycle update and the lru read-modify-write
`timescale 1ns/100ps

module btb_fetch_front (
    input  logic                                 CLK,
    input  logic                                 nRST,

    // lookup request
    input  logic                                 valid_req,
    input  logic [btb_pkg::PC_WIDTH-1:0]         pc_req,
    input  logic [btb_pkg::ASID_WIDTH-1:0]       asid,

    // update, first cycle
    input  logic                                 update0_valid,
    input  logic [btb_pkg::PC_WIDTH-1:0]         update0_pc,

    // update, second cycle
    input  logic [btb_pkg::PRED_INFO_WIDTH-1:0]  update1_pred_info,
    input  logic                                 update1_pred_lru,
    input  logic [btb_pkg::PC_WIDTH-1:0]         update1_target_pc,

    // bank read side
    output logic                                 bank_ren,
    output logic [btb_pkg::INDEX_WIDTH-1:0]      bank_rindex,
    output logic [btb_pkg::TAG_WIDTH-1:0]        resp_tag,

    // response cycle
    output logic                                 resp_valid,
    output logic [btb_pkg::LOG_NSLOTS-1:0]       resp_offset,
    output btb_pkg::lru_vec_t                    resp_lru,

    // bank write side
    output logic [btb_pkg::NSLOTS-1:0]           wr_slot_en,
    output logic [btb_pkg::INDEX_WIDTH-1:0]      wr_index,
    output logic                                 wr_way,
    output btb_pkg::btb_entry_t                  wr_entry
);

    import btb_pkg::*;

    // lookup decode
    logic [INDEX_WIDTH-1:0] req_index;
    logic [LOG_NSLOTS-1:0]  req_offset;
    logic [TAG_WIDTH-1:0]   req_tag;

    // update stage 0
    logic [INDEX_WIDTH-1:0] upd0_index;
    logic [LOG_NSLOTS-1:0]  upd0_slot;
    logic [TAG_WIDTH-1:0]   upd0_tag;

    // update stage 1
    logic                   upd1_valid;
    logic [INDEX_WIDTH-1:0] upd1_index;
    logic [LOG_NSLOTS-1:0]  upd1_slot;
    logic [TAG_WIDTH-1:0]   upd1_tag;
    lru_vec_t               upd1_old_lru;
    lru_vec_t               upd1_new_lru;

    // ---------------------------------------------------------
    // lookup request
    assign req_index  = pc_req[INDEX_LSB +: INDEX_WIDTH];
    assign req_offset = pc_req[OFFSET_LSB +: LOG_NSLOTS];

    btb_tag_hash u_req_hash (.pc(pc_req), .asid(asid), .tag(req_tag));

    // banks read straight off the request
    assign bank_ren    = valid_req;
    assign bank_rindex = req_index;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= valid_req;
        end
    end

    // tag and offset follow into the response cycle
    always_ff @(posedge CLK) begin
        resp_tag    <= req_tag;
        resp_offset <= req_offset;
    end

    // ---------------------------------------------------------
    // update pipeline
    assign upd0_index = update0_pc[INDEX_LSB +: INDEX_WIDTH];
    assign upd0_slot  = update0_pc[OFFSET_LSB +: LOG_NSLOTS];

    // asid comes from the shared request port
    btb_tag_hash u_upd_hash (.pc(update0_pc), .asid(asid), .tag(upd0_tag));

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            upd1_valid <= 1'b0;
        end else begin
            upd1_valid <= update0_valid;
        end
    end

    always_ff @(posedge CLK) begin
        upd1_index <= upd0_index;
        upd1_slot  <= upd0_slot;
        upd1_tag   <= upd0_tag;
    end

    // swap in the new bit for the written slot only
    always_comb begin
        upd1_new_lru            = upd1_old_lru;
        upd1_new_lru[upd1_slot] = update1_pred_lru;
    end

    // ---------------------------------------------------------
    // lru copies
    // lookup copy, read at request time
    btb_ram #(.data_t(lru_vec_t), .DEPTH(BTB_SETS)) u_lru_lookup (
        .CLK(CLK), .nRST(nRST),
        .ren(valid_req), .rindex(req_index), .rdata(resp_lru),
        .wen(upd1_valid), .windex(upd1_index), .wdata(upd1_new_lru)
    );

    // update copy, read in stage 0, lands in stage 1
    btb_ram #(.data_t(lru_vec_t), .DEPTH(BTB_SETS)) u_lru_update (
        .CLK(CLK), .nRST(nRST),
        .ren(update0_valid), .rindex(upd0_index), .rdata(upd1_old_lru),
        .wen(upd1_valid), .windex(upd1_index), .wdata(upd1_new_lru)
    );

    // ---------------------------------------------------------
    // entry write
    // one-hot over slots, way is the predicted lru bit
    assign wr_slot_en = upd1_valid ? (NSLOTS'(1) << upd1_slot) : '0;
    assign wr_index   = upd1_index;
    assign wr_way     = update1_pred_lru;

    always_comb begin
        wr_entry.pred_info = update1_pred_info;
        wr_entry.tag       = upd1_tag;
        wr_entry.target    = update1_target_pc[TARGET_LSB +: TARGET_WIDTH];
    end

endmodule

//--- src/btb_pkg.sv
// btb package: widths, pc field positions and the stored entry and lru types
package btb_pkg;

    // ---------------------------------------------------------
    // geometry
    // four 2-byte slots per fetch block, two ways per slot
    localparam int NSLOTS     = 4;
    localparam int LOG_NSLOTS = 2;
    localparam int NWAYS      = 2;
    localparam int BTB_SETS   = 64;

    // ---------------------------------------------------------
    // widths
    localparam int PC_WIDTH        = 32;
    localparam int INDEX_WIDTH     = 6;
    localparam int TAG_WIDTH       = 8;
    localparam int ASID_WIDTH      = 8;
    localparam int PRED_INFO_WIDTH = 8;
    localparam int TARGET_WIDTH    = 16;

    // ---------------------------------------------------------
    // pc field positions
    // slot offset in pc[2:1], set index in pc[8:3]
    localparam int OFFSET_LSB = 1;
    localparam int INDEX_LSB  = 3;
    // two tag folds start here, pc[16:9] and pc[24:17]
    localparam int TAG_LSB    = 9;
    // target field is target pc[16:1]
    localparam int TARGET_LSB = 1;

    // one way of one slot, 32 bits
    typedef struct packed {
        logic [PRED_INFO_WIDTH-1:0] pred_info;
        logic [TAG_WIDTH-1:0]       tag;
        logic [TARGET_WIDTH-1:0]    target;
    } btb_entry_t;

    // one lru bit per slot of a set
    typedef logic [NSLOTS-1:0] lru_vec_t;

endpackage

//--- src/btb_ram.sv
// btb ram: one read port, one write port, registered read, flop array cleared on reset
`timescale 1ns/100ps

module btb_ram #(
    parameter type data_t = logic,
    parameter int  DEPTH  = 64
) (
    input  logic                     CLK,
    input  logic                     nRST,

    // read port
    input  logic                     ren,
    input  logic [$clog2(DEPTH)-1:0] rindex,
    output data_t                    rdata,

    // write port
    input  logic                     wen,
    input  logic [$clog2(DEPTH)-1:0] windex,
    input  data_t                    wdata
);

    data_t mem [DEPTH];

    // ---------------------------------------------------------
    // storage
    // whole array zeroed so early lookups are defined
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wen) begin
            mem[windex] <= wdata;
        end
    end

    // ---------------------------------------------------------
    // read
    // same-edge write not forwarded, old data returned
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            rdata <= '0;
        end else if (ren) begin
            rdata <= mem[rindex];
        end
    end

endmodule

//--- src/btb_resp_collect.sv
// btb response collector: merges slot results with lru and finds the first hit from the offset
`timescale 1ns/100ps

module btb_resp_collect (
    // response cycle from the front end
    input  logic                                              resp_valid,
    input  logic [btb_pkg::LOG_NSLOTS-1:0]                    resp_offset,
    input  btb_pkg::lru_vec_t                                 resp_lru,

    // per-slot bank results
    input  logic [btb_pkg::NSLOTS-1:0]                        hit,
    input  logic [btb_pkg::NSLOTS-1:0]                        hit_way,
    input  logic [btb_pkg::NSLOTS-1:0][btb_pkg::PRED_INFO_WIDTH-1:0] pred_info,
    input  logic [btb_pkg::NSLOTS-1:0][btb_pkg::TARGET_WIDTH-1:0]    target,

    // per-slot outputs
    output logic [btb_pkg::NSLOTS-1:0]                        hit_by_slot,
    output logic [btb_pkg::NSLOTS-1:0][btb_pkg::PRED_INFO_WIDTH-1:0] pred_info_by_slot,
    output logic [btb_pkg::NSLOTS-1:0][btb_pkg::TARGET_WIDTH-1:0]    target_by_slot,
    output logic [btb_pkg::NSLOTS-1:0]                        lru_by_slot,

    // first predicted slot in the block
    output logic                                              first_hit_valid,
    output logic [btb_pkg::LOG_NSLOTS-1:0]                    first_hit_slot,
    output logic [btb_pkg::TARGET_WIDTH-1:0]                  first_hit_target
);

    import btb_pkg::*;

    logic                  found;
    logic [LOG_NSLOTS-1:0] found_slot;

    // ---------------------------------------------------------
    // per-slot merge
    assign hit_by_slot       = hit;
    assign pred_info_by_slot = pred_info;
    assign target_by_slot    = target;

    // hit reports its own way, miss keeps the stored bit
    always_comb begin
        for (int i = 0; i < NSLOTS; i++) begin
            lru_by_slot[i] = hit[i] ? hit_way[i] : resp_lru[i];
        end
    end

    // ---------------------------------------------------------
    // first hit search
    // walk down so the lowest qualifying slot is left last
    always_comb begin
        found      = 1'b0;
        found_slot = '0;
        for (int i = NSLOTS - 1; i >= 0; i--) begin
            if (hit[i] && (LOG_NSLOTS'(i) >= resp_offset)) begin
                found      = 1'b1;
                found_slot = LOG_NSLOTS'(i);
            end
        end
    end

    // only meaningful in the response cycle
    assign first_hit_valid  = resp_valid && found;
    assign first_hit_slot   = found_slot;
    assign first_hit_target = target[found_slot];

endmodule

//--- src/btb_slot_bank.sv
// btb slot bank: two ways of one slot with valid bits, tag compare and way select
`timescale 1ns/100ps

module btb_slot_bank (
    input  logic                                 CLK,
    input  logic                                 nRST,

    // lookup
    input  logic                                 ren,
    input  logic [btb_pkg::INDEX_WIDTH-1:0]      rindex,
    input  logic [btb_pkg::TAG_WIDTH-1:0]        resp_tag,

    // write
    input  logic                                 wen,
    input  logic [btb_pkg::INDEX_WIDTH-1:0]      windex,
    input  logic                                 wway,
    input  btb_pkg::btb_entry_t                  wentry,

    // response
    output logic                                 hit,
    output logic                                 hit_way,
    output logic [btb_pkg::PRED_INFO_WIDTH-1:0]  pred_info,
    output logic [btb_pkg::TARGET_WIDTH-1:0]     target
);

    import btb_pkg::*;

    btb_entry_t                       way_rdata [NWAYS];
    logic [BTB_SETS-1:0][NWAYS-1:0]   valid_q;
    logic [NWAYS-1:0]                 rd_valid;
    logic [NWAYS-1:0]                 way_match;

    // ---------------------------------------------------------
    // ways
    generate
        for (genvar w = 0; w < NWAYS; w++) begin : g_way
            btb_ram #(.data_t(btb_entry_t), .DEPTH(BTB_SETS)) u_ram (
                .CLK(CLK), .nRST(nRST),
                .ren(ren), .rindex(rindex), .rdata(way_rdata[w]),
                .wen(wen && (wway == 1'(w))), .windex(windex), .wdata(wentry)
            );

            // valid and tag equal
            assign way_match[w] = rd_valid[w] && (way_rdata[w].tag == resp_tag);
        end
    endgenerate

    // ---------------------------------------------------------
    // valid bits
    // set on write, never cleared short of reset
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
        end else if (wen) begin
            valid_q[windex][wway] <= 1'b1;
        end
    end

    // read alongside the ram so they line up
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            rd_valid <= '0;
        end else if (ren) begin
            rd_valid <= valid_q[rindex];
        end
    end

    // ---------------------------------------------------------
    // way select
    // way 0 wins a double match
    assign hit     = |way_match;
    assign hit_way = !way_match[0] && way_match[1];

    // a miss leaves hit_way at 0, so fields fall back to way 0
    assign pred_info = way_rdata[hit_way].pred_info;
    assign target    = way_rdata[hit_way].target;

endmodule

//--- src/btb_tag_hash.sv
// btb tag hash: folds two pc fields and the address-space id into a short tag
`timescale 1ns/100ps

module btb_tag_hash (
    input  logic [btb_pkg::PC_WIDTH-1:0]   pc,
    input  logic [btb_pkg::ASID_WIDTH-1:0] asid,
    output logic [btb_pkg::TAG_WIDTH-1:0]  tag
);

    import btb_pkg::*;

    logic [TAG_WIDTH-1:0] fold_lo;
    logic [TAG_WIDTH-1:0] fold_hi;

    // low fold just above the set index
    assign fold_lo = pc[TAG_LSB +: TAG_WIDTH];
    // next tag-width chunk up
    assign fold_hi = pc[TAG_LSB+TAG_WIDTH +: TAG_WIDTH];

    // asid mixed in so spaces alias less
    assign tag = fold_lo ^ fold_hi ^ asid;

endmodule

//--- test/btb_properties.sv
// btb properties: response strobe timing, first-hit consistency, write enable out of reset
`timescale 1ns/100ps

module btb_properties (
    input logic                        CLK,
    input logic                        nRST,
    input logic                        valid_req,
    input logic                        resp_valid,
    input logic                        first_hit_valid,
    input logic [btb_pkg::LOG_NSLOTS-1:0] first_hit_slot,
    input logic [btb_pkg::NSLOTS-1:0]  hit_by_slot,
    input logic [btb_pkg::NSLOTS-1:0]  wr_slot_en
);

    import btb_pkg::*;

    // failed assertions, watched from the testbench
    int error_count = 0;

    // ------------------------------------------------------------
    // lookup strobe, exactly one cycle later
    a_resp_after_req: assert property (
        @(posedge CLK) disable iff (!nRST) valid_req |=> resp_valid
    ) else begin
        error_count++;
        $error("resp_valid missing one cycle after valid_req");
    end

    // no response without a request
    a_no_resp_without_req: assert property (
        @(posedge CLK) disable iff (!nRST) !valid_req |=> !resp_valid
    ) else begin
        error_count++;
        $error("resp_valid raised without a valid_req the cycle before");
    end

    // ------------------------------------------------------------
    // first hit only in a response cycle, on a slot that hit
    a_first_hit_consistent: assert property (
        @(posedge CLK) disable iff (!nRST)
        first_hit_valid |-> (resp_valid && hit_by_slot[first_hit_slot])
    ) else begin
        error_count++;
        $error("first_hit_valid without resp_valid or without a hit in the chosen slot");
    end

    // nothing written in the first cycle out of reset
    a_no_write_after_reset: assert property (
        @(posedge CLK) $rose(nRST) |-> (wr_slot_en == '0)
    ) else begin
        error_count++;
        $error("slot write enable high in the first cycle after reset");
    end

endmodule

//--- test/btb_tb.sv
// btb testbench: directed and random lookups and updates against a reference model
`timescale 1ns/100ps

module btb_tb;

    import btb_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 5;
    localparam int SEED         = 99375;
    localparam int N_RANDOM     = 24;
    // directed ops plus one update and two lookups per random round
    localparam int TOTAL_OPS       = 16 + 3 + 3 + 4 + 3 * N_RANDOM;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 2 * TOTAL_OPS + 50;

    logic                                    CLK;
    logic                                    nRST;
    logic                                    valid_req;
    logic [PC_WIDTH-1:0]                     pc_req;
    logic [ASID_WIDTH-1:0]                   asid;
    logic                                    update0_valid;
    logic [PC_WIDTH-1:0]                     update0_pc;
    logic [PRED_INFO_WIDTH-1:0]              update1_pred_info;
    logic                                    update1_pred_lru;
    logic [PC_WIDTH-1:0]                     update1_target_pc;
    logic                                    resp_valid;
    logic [NSLOTS-1:0]                       hit_by_slot;
    logic [NSLOTS-1:0][PRED_INFO_WIDTH-1:0]  pred_info_by_slot;
    logic [NSLOTS-1:0][TARGET_WIDTH-1:0]     target_by_slot;
    logic [NSLOTS-1:0]                       lru_by_slot;
    logic                                    first_hit_valid;
    logic [LOG_NSLOTS-1:0]                   first_hit_slot;
    logic [TARGET_WIDTH-1:0]                 first_hit_target;

    // reference model, cleared like the rams
    btb_entry_t model_entry [BTB_SETS][NSLOTS][NWAYS];
    logic       model_valid [BTB_SETS][NSLOTS][NWAYS];
    logic       model_lru   [BTB_SETS][NSLOTS];

    string test_name;

    tb_clock #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clock (
        .CLK(CLK), .nRST(nRST)
    );

    btb DUT (.*);

    bind btb btb_properties u_props (
        .CLK(CLK), .nRST(nRST), .valid_req(valid_req), .resp_valid(resp_valid),
        .first_hit_valid(first_hit_valid), .first_hit_slot(first_hit_slot),
        .hit_by_slot(hit_by_slot), .wr_slot_en(wr_slot_en)
    );

    // ------------------------------------------------------------
    // failure handling
    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("FAIL %s %s: expected 0x%0h, actual 0x%0h", test_name, what, exp, act);
        abort_run();
    endtask

    // first failed bound assertion ends the run
    always @(negedge CLK) begin
        if (DUT.u_props.error_count != 0) begin
            $display("a bound assertion on the DUT failed in test %s", test_name);
            abort_run();
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
        abort_run();
    end

    // ------------------------------------------------------------
    // model helpers
    // xor of pc[16:9], pc[24:17] and the asid
    function automatic logic [TAG_WIDTH-1:0] fold_tag(input logic [31:0] pc,
                                                       input logic [7:0] id);
        return pc[16:9] ^ pc[24:17] ^ id;
    endfunction

    task automatic drive_edge();
        @(posedge CLK);
        #1;
    endtask

    // two-cycle update, model written alongside
    task automatic do_update(input logic [31:0] pc, input logic [7:0] id,
                             input logic [7:0] pred, input logic way,
                             input logic [31:0] tpc);
        drive_edge();
        update0_valid = 1'b1;
        update0_pc    = pc;
        asid          = id;
        drive_edge();
        update0_valid     = 1'b0;
        update1_pred_info = pred;
        update1_pred_lru  = way;
        update1_target_pc = tpc;
        model_entry[pc[8:3]][pc[2:1]][way] = '{pred, fold_tag(pc, id), tpc[16:1]};
        model_valid[pc[8:3]][pc[2:1]][way] = 1'b1;
        model_lru[pc[8:3]][pc[2:1]]        = way;
    endtask

    // response checked in the cycle right after the request
    task automatic check_response(input logic [31:0] pc, input logic [7:0] id);
        logic [INDEX_WIDTH-1:0]  idx;
        logic [TAG_WIDTH-1:0]    tag;
        logic                    m0;
        logic                    m1;
        logic                    hit;
        logic                    way;
        logic                    found;
        int                      first;
        logic [TARGET_WIDTH-1:0] first_target;
        btb_entry_t              e;
        idx          = pc[8:3];
        tag          = fold_tag(pc, id);
        found        = 1'b0;
        first        = 0;
        first_target = '0;
        assert (resp_valid === 1'b1) else report_mismatch("resp_valid", 1, resp_valid);
        for (int s = 0; s < NSLOTS; s++) begin
            m0  = model_valid[idx][s][0] && (model_entry[idx][s][0].tag == tag);
            m1  = model_valid[idx][s][1] && (model_entry[idx][s][1].tag == tag);
            hit = m0 || m1;
            // way 0 wins, and a miss shows way 0 fields
            way = !m0 && m1;
            e   = model_entry[idx][s][way];
            assert (hit_by_slot[s] === hit)
                else report_mismatch($sformatf("hit[%0d]", s), hit, hit_by_slot[s]);
            assert (pred_info_by_slot[s] === e.pred_info)
                else report_mismatch($sformatf("pred_info[%0d]", s), e.pred_info,
                                     pred_info_by_slot[s]);
            assert (target_by_slot[s] === e.target)
                else report_mismatch($sformatf("target[%0d]", s), e.target,
                                     target_by_slot[s]);
            assert (lru_by_slot[s] === (hit ? way : model_lru[idx][s]))
                else report_mismatch($sformatf("lru[%0d]", s),
                                     hit ? way : model_lru[idx][s], lru_by_slot[s]);
            if (hit && !found && (s >= pc[2:1])) begin
                found        = 1'b1;
                first        = s;
                first_target = e.target;
            end
        end
        assert (first_hit_valid === found)
            else report_mismatch("first_hit_valid", found, first_hit_valid);
        if (found) begin
            assert (first_hit_slot === LOG_NSLOTS'(first))
                else report_mismatch("first_hit_slot", first, first_hit_slot);
            assert (first_hit_target === first_target)
                else report_mismatch("first_hit_target", first_target, first_hit_target);
        end
    endtask

    task automatic do_lookup(input logic [31:0] pc, input logic [7:0] id);
        drive_edge();
        valid_req = 1'b1;
        pc_req    = pc;
        asid      = id;
        drive_edge();
        valid_req = 1'b0;
        check_response(pc, id);
    endtask

    // ------------------------------------------------------------
    // main sequence
    initial begin
        logic [31:0] pc_a;
        logic [31:0] pc_b;
        logic [31:0] pool_pc [4];
        logic [7:0]  pool_asid [2];
        logic [31:0] blk;
        logic [7:0]  id;
        logic [1:0]  slot;
        void'($urandom(SEED));
        valid_req         = 1'b0;
        pc_req            = '0;
        asid              = '0;
        // update strobe held through reset, must not turn into a write
        update0_valid     = 1'b1;
        update0_pc        = '0;
        update1_pred_info = '0;
        update1_pred_lru  = 1'b0;
        update1_target_pc = '0;
        foreach (model_entry[i, j, k]) begin
            model_entry[i][j][k] = '0;
            model_valid[i][j][k] = 1'b0;
        end
        foreach (model_lru[i, j]) begin
            model_lru[i][j] = 1'b0;
        end
        test_name = "reset_state";
        @(posedge nRST);
        update0_valid = 1'b0;
        // empty table, all miss with lru 0
        repeat (16) do_lookup($urandom, 8'($urandom));

        test_name = "update_then_hit";
        pc_a = 32'h0041_2a6c;
        do_update(pc_a, 8'h5a, 8'hc3, 1'b1, 32'h0001_beef);
        do_lookup(pc_a, 8'h5a);
        // same block from offset 0, first hit still the written slot
        do_lookup(pc_a & ~32'h6, 8'h5a);

        test_name = "tag_mismatch";
        do_lookup(pc_a, 8'h5b);
        // low and high tag folds
        do_lookup(pc_a ^ 32'h0000_0200, 8'h5a);
        do_lookup(pc_a ^ 32'h0004_0000, 8'h5a);

        test_name = "way_priority";
        pc_b = 32'h0103_9d42;
        do_update(pc_b, 8'h33, 8'h01, 1'b0, 32'h0000_1110);
        do_update(pc_b, 8'h33, 8'h02, 1'b1, 32'h0000_2220);
        do_lookup(pc_b, 8'h33);
        // miss shows lru from the last update
        do_lookup(pc_b, 8'h34);

        test_name = "random_first_hit";
        // few blocks over two sets so ways collide
        for (int k = 0; k < 4; k++) begin
            pool_pc[k]      = $urandom & ~32'h1ff;
            pool_pc[k][8:3] = (k < 2) ? 6'h05 : 6'h2a;
        end
        pool_asid[0] = 8'h11;
        pool_asid[1] = 8'h22;
        for (int n = 0; n < N_RANDOM; n++) begin
            blk  = pool_pc[$urandom_range(3)];
            id   = pool_asid[$urandom_range(1)];
            slot = 2'($urandom);
            do_update(blk | {29'd0, slot, 1'b0}, id, 8'($urandom), 1'($urandom), $urandom);
            repeat (2) begin
                blk = pool_pc[$urandom_range(3)];
                id  = pool_asid[$urandom_range(1)];
                do_lookup(blk | (32'($urandom_range(3)) << 1), id);
            end
        end

        drive_edge();
        if (DUT.u_props.error_count == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule

//--- test/tb_clock.sv
// tb clock: free-running clock and an active-low reset held for a few cycles
`timescale 1ns/100ps

module tb_clock #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 5
) (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;
        forever #(PERIOD / 2) CLK = ~CLK;
    end

    // release just after an edge, like the rest of the stimulus
    initial begin
        nRST = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        #1;
        nRST = 1'b1;
    end

endmodule
